// ==== src/bus_pkg.sv ====
package bus_pkg;

  // One master or slave request. A zero wstrb marks a read.
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } bus_rsp_t;

  // Target of an access. sel_none covers every unmapped address.
  typedef enum logic [2:0] {
    sel_iram  = 3'd0,
    sel_dram  = 3'd1,
    sel_uart  = 3'd2,
    sel_timer = 3'd3,
    sel_none  = 3'd4
  } slave_sel_t;

endpackage

// ==== src/map_pkg.sv ====
package map_pkg;

  // Each base is aligned to the size of its region.
  localparam logic [31:0] IRAM_BASE  = 32'h0000_0000;
  localparam logic [31:0] DRAM_BASE  = 32'h0001_0000;
  localparam logic [31:0] UART_BASE  = 32'h0010_0000;
  localparam logic [31:0] TIMER_BASE = 32'h0020_0000;

  localparam logic [31:0] IRAM_SIZE  = 32'h0001_0000;
  localparam logic [31:0] DRAM_SIZE  = 32'h0001_0000;
  localparam logic [31:0] UART_SIZE  = 32'h0000_1000;
  localparam logic [31:0] TIMER_SIZE = 32'h0000_1000;

  // Register offsets inside the timer region.
  localparam logic [31:0] TIMER_COUNT_OFS = 32'h0000_0000;
  localparam logic [31:0] TIMER_CMP_OFS   = 32'h0000_0004;

  // Register offsets inside the UART region.
  localparam logic [31:0] UART_DATA_OFS = 32'h0000_0000;
  localparam logic [31:0] UART_STAT_OFS = 32'h0000_0004;

endpackage

// ==== src/bus_switch.sv ====
`timescale 1ns/1ps

module bus_switch import bus_pkg::*; import map_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t imem_req_i,
  input  bus_req_t dmem_req_i,
  output bus_rsp_t imem_rsp_o,
  output bus_rsp_t dmem_rsp_o,
  output bus_req_t iram_req_o,
  output bus_req_t dram_req_o,
  output bus_req_t uart_req_o,
  output bus_req_t timer_req_o,
  input  bus_rsp_t iram_rsp_i,
  input  bus_rsp_t dram_rsp_i,
  input  bus_rsp_t uart_rsp_i,
  input  bus_rsp_t timer_rsp_i
);

  slave_sel_t imem_sel;
  slave_sel_t dmem_sel;
  slave_sel_t imem_pend;
  slave_sel_t dmem_pend;
  slave_sel_t imem_claim;
  slave_sel_t dmem_claim;
  logic       imem_busy;
  logic       dmem_busy;
  logic       imem_start;
  logic       dmem_start;

  function automatic slave_sel_t decode(logic [31:0] addr);
    if ((addr & ~(IRAM_SIZE - 1)) == IRAM_BASE) return sel_iram;
    if ((addr & ~(DRAM_SIZE - 1)) == DRAM_BASE) return sel_dram;
    if ((addr & ~(UART_SIZE - 1)) == UART_BASE) return sel_uart;
    if ((addr & ~(TIMER_SIZE - 1)) == TIMER_BASE) return sel_timer;
    return sel_none;
  endfunction

  // The data port wins a slave it claims, and the region base is cleared from the address.
  function automatic bus_req_t pick(slave_sel_t tgt, logic [31:0] size,
                                    slave_sel_t d_claim, slave_sel_t i_claim,
                                    bus_req_t d_req, bus_req_t i_req);
    bus_req_t r;
    r = '0;
    if (d_claim == tgt) begin
      r = d_req;
    end else if (i_claim == tgt) begin
      r = i_req;
    end
    r.addr = r.addr & (size - 1);
    return r;
  endfunction

  // A pending access to an unmapped address is answered here with zero data.
  function automatic bus_rsp_t select_rsp(logic busy, slave_sel_t pend,
                                          bus_rsp_t iram, bus_rsp_t dram,
                                          bus_rsp_t uart, bus_rsp_t timer);
    bus_rsp_t r;
    r = '0;
    if (busy) begin
      case (pend)
        sel_iram:  r = iram;
        sel_dram:  r = dram;
        sel_uart:  r = uart;
        sel_timer: r = timer;
        default:   r.ready = 1'b1;
      endcase
    end
    return r;
  endfunction

  assign imem_sel = decode(imem_req_i.addr);
  assign dmem_sel = decode(dmem_req_i.addr);

  // A new request may not take a slave that the other master still has pending.
  assign dmem_start = dmem_req_i.valid && !dmem_busy &&
                      !(imem_busy && imem_pend == dmem_sel && dmem_sel != sel_none);
  assign imem_start = imem_req_i.valid && !imem_busy && !(imem_sel != sel_none &&
                      (dmem_busy ? dmem_pend == imem_sel
                                 : dmem_req_i.valid && dmem_sel == imem_sel));

  assign dmem_claim = dmem_busy ? dmem_pend : (dmem_start ? dmem_sel : sel_none);
  assign imem_claim = imem_busy ? imem_pend : (imem_start ? imem_sel : sel_none);

  assign iram_req_o  = pick(sel_iram, IRAM_SIZE, dmem_claim, imem_claim,
                            dmem_req_i, imem_req_i);
  assign dram_req_o  = pick(sel_dram, DRAM_SIZE, dmem_claim, imem_claim,
                            dmem_req_i, imem_req_i);
  assign uart_req_o  = pick(sel_uart, UART_SIZE, dmem_claim, imem_claim,
                            dmem_req_i, imem_req_i);
  assign timer_req_o = pick(sel_timer, TIMER_SIZE, dmem_claim, imem_claim,
                            dmem_req_i, imem_req_i);

  assign imem_rsp_o = select_rsp(imem_busy, imem_pend, iram_rsp_i, dram_rsp_i,
                                 uart_rsp_i, timer_rsp_i);
  assign dmem_rsp_o = select_rsp(dmem_busy, dmem_pend, iram_rsp_i, dram_rsp_i,
                                 uart_rsp_i, timer_rsp_i);

  always_ff @(posedge clk) begin
    if (!rst) begin
      imem_busy <= 1'b0;
      imem_pend <= sel_none;
      dmem_busy <= 1'b0;
      dmem_pend <= sel_none;
    end else begin
      if (imem_busy) begin
        if (imem_rsp_o.ready) begin
          imem_busy <= 1'b0;
          imem_pend <= sel_none;
        end
      end else if (imem_start) begin
        imem_busy <= 1'b1;
        imem_pend <= imem_sel;
      end
      if (dmem_busy) begin
        if (dmem_rsp_o.ready) begin
          dmem_busy <= 1'b0;
          dmem_pend <= sel_none;
        end
      end else if (dmem_start) begin
        dmem_busy <= 1'b1;
        dmem_pend <= dmem_sel;
      end
    end
  end

endmodule

// ==== src/ram_slave.sv ====
`timescale 1ns/1ps

module ram_slave import bus_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [31:0]      mem [RAM_WORDS];
  logic [31:0]      rdata_q;
  logic             ready_q;
  logic             accept;
  logic [IDX_W-1:0] idx;

  // The depth is a power of two, so dropping the upper bits wraps the address.
  assign idx    = req_i.addr[IDX_W+1:2];
  assign accept = req_i.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  // A write returns the word as it was before the write.
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;

endmodule

// ==== src/timer_slave.sv ====
`timescale 1ns/1ps

module timer_slave import bus_pkg::*; import map_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     irq_o
);

  logic [31:0] count_q;
  logic [31:0] count_d;
  logic [31:0] cmp_q;
  logic [31:0] cmp_d;
  logic [31:0] rdata_q;
  logic        ready_q;
  logic        irq_q;
  logic        accept;
  logic        wr;

  assign accept = req_i.valid && !ready_q;
  assign wr     = accept && (req_i.wstrb != 4'b0000);

  always_comb begin
    count_d = count_q + 32'd1;
    cmp_d   = cmp_q;
    if (wr && req_i.addr == TIMER_COUNT_OFS) begin
      count_d = req_i.wdata;
    end
    if (wr && req_i.addr == TIMER_CMP_OFS) begin
      cmp_d = req_i.wdata;
    end
  end

  // The interrupt follows the new values, so a compare write takes effect at once.
  always_ff @(posedge clk) begin
    if (!rst) begin
      count_q <= '0;
      cmp_q   <= '1;
      irq_q   <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      count_q <= count_d;
      cmp_q   <= cmp_d;
      irq_q   <= (count_d >= cmp_d);
      ready_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (req_i.addr)
        TIMER_COUNT_OFS: rdata_q <= count_q;
        TIMER_CMP_OFS:   rdata_q <= cmp_q;
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;
  assign irq_o       = irq_q;

endmodule

// ==== src/uart_tx_slave.sv ====
`timescale 1ns/1ps

module uart_tx_slave import bus_pkg::*; import map_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,
  output logic     tx_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [8:0]       shift_q;
  logic [3:0]       bit_cnt;
  logic [CNT_W-1:0] clk_cnt;
  logic             busy_q;
  logic             tx_q;
  logic             ready_q;
  logic [31:0]      rdata_q;
  logic             data_wr;
  logic             accept;

  // A data write waits while a frame is on the line.
  assign data_wr = (req_i.wstrb != 4'b0000) && (req_i.addr == UART_DATA_OFS);
  assign accept  = req_i.valid && !ready_q && !(data_wr && busy_q);

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy_q  <= 1'b0;
      tx_q    <= 1'b1;
      ready_q <= 1'b0;
      bit_cnt <= '0;
      clk_cnt <= '0;
    end else begin
      ready_q <= accept;
      if (accept && data_wr) begin
        busy_q  <= 1'b1;
        tx_q    <= 1'b0;
        bit_cnt <= 4'd9;
        clk_cnt <= '0;
      end else if (busy_q) begin
        if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
          clk_cnt <= '0;
          if (bit_cnt == 4'd0) begin
            busy_q <= 1'b0;
          end else begin
            tx_q    <= shift_q[0];
            bit_cnt <= bit_cnt - 4'd1;
          end
        end else begin
          clk_cnt <= clk_cnt + CNT_W'(1);
        end
      end
    end
  end

  // The stop bit sits above the data byte and fills in as the byte shifts out.
  always_ff @(posedge clk) begin
    if (accept && data_wr) begin
      shift_q <= {1'b1, req_i.wdata[7:0]};
    end else if (busy_q && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && bit_cnt != 4'd0) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
    if (accept) begin
      rdata_q <= (req_i.addr == UART_STAT_OFS) ? {31'b0, busy_q} : '0;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_q;
  assign tx_o        = tx_q;

endmodule

// ==== src/soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric import bus_pkg::*; #(
  parameter int RAM_WORDS    = 256,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t imem_req_i,
  input  bus_req_t dmem_req_i,
  output bus_rsp_t imem_rsp_o,
  output bus_rsp_t dmem_rsp_o,
  output logic     timer_irq_o,
  output logic     tx_o
);

  bus_req_t iram_req;
  bus_req_t dram_req;
  bus_req_t uart_req;
  bus_req_t timer_req;
  bus_rsp_t iram_rsp;
  bus_rsp_t dram_rsp;
  bus_rsp_t uart_rsp;
  bus_rsp_t timer_rsp;

  bus_switch u_switch (
    .clk         (clk),
    .rst         (rst),
    .imem_req_i  (imem_req_i),
    .dmem_req_i  (dmem_req_i),
    .imem_rsp_o  (imem_rsp_o),
    .dmem_rsp_o  (dmem_rsp_o),
    .iram_req_o  (iram_req),
    .dram_req_o  (dram_req),
    .uart_req_o  (uart_req),
    .timer_req_o (timer_req),
    .iram_rsp_i  (iram_rsp),
    .dram_rsp_i  (dram_rsp),
    .uart_rsp_i  (uart_rsp),
    .timer_rsp_i (timer_rsp)
  );

  ram_slave #(.RAM_WORDS(RAM_WORDS)) u_iram (
    .clk   (clk),
    .rst   (rst),
    .req_i (iram_req),
    .rsp_o (iram_rsp)
  );

  ram_slave #(.RAM_WORDS(RAM_WORDS)) u_dram (
    .clk   (clk),
    .rst   (rst),
    .req_i (dram_req),
    .rsp_o (dram_rsp)
  );

  uart_tx_slave #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
    .clk   (clk),
    .rst   (rst),
    .req_i (uart_req),
    .rsp_o (uart_rsp),
    .tx_o  (tx_o)
  );

  timer_slave u_timer (
    .clk   (clk),
    .rst   (rst),
    .req_i (timer_req),
    .rsp_o (timer_rsp),
    .irq_o (timer_irq_o)
  );

endmodule

// ==== bench/soc_fabric_assert.sv ====
`timescale 1ns/1ps

module soc_fabric_assert import bus_pkg::*; (
  input logic       clk,
  input logic       rst,
  input bus_req_t   imem_req_i,
  input bus_req_t   dmem_req_i,
  input bus_rsp_t   imem_rsp_i,
  input bus_rsp_t   dmem_rsp_i,
  input slave_sel_t imem_pend_i,
  input slave_sel_t dmem_pend_i
);

  // A response only answers a request that was raised the cycle before.
  imem_ready_has_req: assert property (@(posedge clk) disable iff (!rst)
    imem_rsp_i.ready |-> $past(imem_req_i.valid))
    else $error("imem ready without a request");

  dmem_ready_has_req: assert property (@(posedge clk) disable iff (!rst)
    dmem_rsp_i.ready |-> $past(dmem_req_i.valid))
    else $error("dmem ready without a request");

  // Both masters never hold the same mapped slave.
  one_owner: assert property (@(posedge clk) disable iff (!rst)
    !(imem_pend_i == dmem_pend_i && imem_pend_i != sel_none))
    else $error("two masters pending on one slave");

  idle_after_reset: assert property (@(posedge clk)
    $rose(rst) |-> (imem_pend_i == sel_none && dmem_pend_i == sel_none))
    else $error("pending registers not idle after reset");

endmodule

bind bus_switch soc_fabric_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .imem_req_i  (imem_req_i),
  .dmem_req_i  (dmem_req_i),
  .imem_rsp_i  (imem_rsp_o),
  .dmem_rsp_i  (dmem_rsp_o),
  .imem_pend_i (imem_pend),
  .dmem_pend_i (dmem_pend)
);

// ==== bench/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb import bus_pkg::*; import map_pkg::*; ;

  localparam int CLKS_PER_BIT = 8;
  localparam logic [1:0] P_IMEM = 2'd0;
  localparam logic [1:0] P_DMEM = 2'd1;
  localparam logic [1:0] P_BOTH = 2'd2;

  typedef struct packed {
    logic [1:0]  port;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] iaddr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp;
    logic [31:0] iexp;
  } row_t;

  logic     clk;
  logic     rst;
  bus_req_t imem_req;
  bus_req_t dmem_req;
  bus_rsp_t imem_rsp;
  bus_rsp_t dmem_rsp;
  logic     timer_irq;
  logic     tx;

  row_t        rows[$];
  logic [31:0] iram_m [256];
  logic [31:0] dram_m [256];
  logic [7:0]  rx_bytes[$];
  bit          frame_err;
  bit          ok;
  int          n_pass;
  int          n_fail;

  soc_fabric #(.RAM_WORDS(256), .CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
    .clk         (clk),
    .rst         (rst),
    .imem_req_i  (imem_req),
    .dmem_req_i  (dmem_req),
    .imem_rsp_o  (imem_rsp),
    .dmem_rsp_o  (dmem_rsp),
    .timer_irq_o (timer_irq),
    .tx_o        (tx)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] model_read(logic [31:0] a);
    if (a[31:16] == 16'h0000) return iram_m[a[9:2]];
    if (a[31:16] == 16'h0001) return dram_m[a[9:2]];
    return 32'h0;
  endfunction

  task automatic model_write(logic [31:0] a, logic [31:0] d, logic [3:0] s);
    logic [31:0] w;
    w = model_read(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    if (a[31:16] == 16'h0000) iram_m[a[9:2]] = w;
    if (a[31:16] == 16'h0001) dram_m[a[9:2]] = w;
  endtask

  task automatic add_write(logic [31:0] a, logic [31:0] d, logic [3:0] s);
    row_t r;
    r = '{port: P_DMEM, wr: 1'b1, addr: a, iaddr: 32'h0, wdata: d, wstrb: s,
          exp: 32'h0, iexp: 32'h0};
    model_write(a, d, s);
    rows.push_back(r);
  endtask

  task automatic add_read(logic [1:0] p, logic [31:0] a, logic [31:0] ia);
    row_t r;
    r = '{port: p, wr: 1'b0, addr: a, iaddr: ia, wdata: 32'h0, wstrb: 4'h0,
          exp: model_read(a), iexp: model_read(ia)};
    rows.push_back(r);
  endtask

  // Drives one request on a falling edge and waits for its ready pulse.
  task automatic access(input bit on_imem, input logic wr, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] wstrb,
                        output logic [31:0] rdata, output int cycles);
    bus_req_t r;
    bit done;
    r = '0;
    r.valid = 1'b1;
    r.instr = on_imem;
    r.addr = addr;
    r.wdata = wdata;
    r.wstrb = wr ? wstrb : 4'b0000;
    if (on_imem) imem_req = r;
    else dmem_req = r;
    cycles = 0;
    rdata = '0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (on_imem && imem_rsp.ready) begin
        rdata = imem_rsp.rdata;
        imem_req = '0;
        done = 1'b1;
      end else if (!on_imem && dmem_rsp.ready) begin
        rdata = dmem_rsp.rdata;
        dmem_req = '0;
        done = 1'b1;
      end
    end
  endtask

  task automatic access_both(input logic [31:0] daddr, input logic [31:0] iaddr,
                             output logic [31:0] drd, output logic [31:0] ird,
                             output int dcyc, output int icyc);
    int c;
    // Both requests start from an idle cycle, after the last ready pulse has passed.
    @(negedge clk);
    dmem_req = '{valid: 1'b1, instr: 1'b0, addr: daddr, wdata: 32'h0, wstrb: 4'h0};
    imem_req = '{valid: 1'b1, instr: 1'b1, addr: iaddr, wdata: 32'h0, wstrb: 4'h0};
    c = 0;
    dcyc = 0;
    icyc = 0;
    while (dcyc == 0 || icyc == 0) begin
      @(negedge clk);
      c++;
      if (dcyc == 0 && dmem_rsp.ready) begin
        drd = dmem_rsp.rdata;
        dmem_req = '0;
        dcyc = c;
      end
      if (icyc == 0 && imem_rsp.ready) begin
        ird = imem_rsp.rdata;
        imem_req = '0;
        icyc = c;
      end
    end
  endtask

  task automatic expect_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic end_test(string name);
    if (ok) begin
      n_pass++;
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s", name);
    end
    ok = 1'b1;
  endtask

  // Recovers each 8N1 frame on tx by sampling in the middle of every bit.
  initial begin
    logic [7:0] b;
    forever begin
      @(negedge tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0) frame_err = 1'b1;
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (tx !== 1'b1) frame_err = 1'b1;
      rx_bytes.push_back(b);
    end
  end

  initial begin
    int limit;
    #1;
    limit = (rows.size() + 12) * 50 + 2 * 20 * CLKS_PER_BIT + 8;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] ird;
    logic [31:0] c;
    int cyc;
    int icyc;
    int t_first;
    int t_second;
    int t_now;
    clk = 1'b0;
    rst = 1'b0;
    imem_req = '0;
    dmem_req = '0;
    ok = 1'b1;
    void'($urandom(32'hfc6));
    add_write(32'h0000_0010, 32'h1122_3344, 4'hf);
    add_write(32'h0001_0010, 32'haabb_ccdd, 4'hf);
    add_write(32'h0000_0010, 32'h5566_7788, 4'b0101);
    add_write(32'h0001_0010, 32'h99ee_ff00, 4'b1000);
    add_read(P_IMEM, 32'h0000_0010, 32'h0);
    add_read(P_DMEM, 32'h0000_0010, 32'h0);
    add_read(P_IMEM, 32'h0001_0010, 32'h0);
    add_read(P_DMEM, 32'h0001_0010, 32'h0);
    add_read(P_BOTH, 32'h0000_0010, 32'h0000_0010);
    add_read(P_BOTH, 32'h0001_0010, 32'h0001_0010);
    add_read(P_BOTH, 32'h0001_0010, 32'h0000_0010);
    add_read(P_IMEM, 32'h0300_0000, 32'h0);
    add_read(P_DMEM, 32'h0300_0000, 32'h0);
    for (int k = 0; k < 6; k++) begin
      c = (k % 2 == 0) ? 32'h0000_0000 : 32'h0001_0000;
      add_write(c + 32'(4 * (k + 32)), $urandom, 4'hf);
      add_read(P_IMEM, c + 32'(4 * (k + 32)), 32'h0);
    end
    repeat (8) @(negedge clk);
    rst = 1'b1;
    @(negedge clk);

    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].port == P_BOTH) begin
        access_both(rows[i].addr, rows[i].iaddr, rd, ird, cyc, icyc);
        expect_val("dmem_rsp.rdata", rd, rows[i].exp);
        expect_val("imem_rsp.rdata", ird, rows[i].iexp);
        if (rows[i].addr[31:16] == rows[i].iaddr[31:16]) begin
          if (icyc < cyc) begin
            $display("Instruction response came before the data response");
            ok = 1'b0;
          end
        end else if (cyc != 1 || icyc != 1) begin
          $display("Different slaves took %0d and %0d cycles instead of 1", cyc, icyc);
          ok = 1'b0;
        end
      end else begin
        access(rows[i].port == P_IMEM, rows[i].wr, rows[i].addr, rows[i].wdata,
               rows[i].wstrb, rd, cyc);
        if (!rows[i].wr) begin
          expect_val(rows[i].port == P_IMEM ? "imem_rsp.rdata" : "dmem_rsp.rdata",
                     rd, rows[i].exp);
        end
      end
      end_test($sformatf("row %0d addr %h", i, rows[i].addr));
    end

    access(0, 1, TIMER_BASE + TIMER_COUNT_OFS, 32'd1000, 4'hf, rd, cyc);
    access(0, 0, TIMER_BASE + TIMER_COUNT_OFS, 32'h0, 4'h0, rd, cyc);
    if (rd < 32'd1000) begin
      $display("ERR dmem_rsp.rdata %h below written count %h", rd, 32'd1000);
      ok = 1'b0;
    end
    end_test("timer count write");

    access(0, 0, TIMER_BASE + TIMER_COUNT_OFS, 32'h0, 4'h0, c, cyc);
    access(0, 1, TIMER_BASE + TIMER_CMP_OFS, c + 32'd20, 4'hf, rd, cyc);
    expect_val("timer_irq_o", {31'b0, timer_irq}, 32'h0);
    cyc = 0;
    while (!timer_irq && cyc < 40) begin
      @(negedge clk);
      cyc++;
    end
    if (!timer_irq) begin
      $display("Timer interrupt did not rise within 40 cycles");
      ok = 1'b0;
    end
    end_test("timer compare interrupt");

    access(0, 1, TIMER_BASE + TIMER_CMP_OFS, 32'hffff_ffff, 4'hf, rd, cyc);
    expect_val("timer_irq_o", {31'b0, timer_irq}, 32'h0);
    end_test("timer interrupt clear");

    access(0, 1, UART_BASE + UART_DATA_OFS, 32'h0000_00a5, 4'hf, rd, cyc);
    t_first = $time / 20;
    access(0, 0, UART_BASE + UART_STAT_OFS, 32'h0, 4'h0, rd, cyc);
    expect_val("dmem_rsp.rdata", rd, 32'h1);
    access(0, 1, UART_BASE + UART_DATA_OFS, 32'h0000_003c, 4'hf, rd, cyc);
    t_second = $time / 20;
    if (t_second - t_first < 10 * CLKS_PER_BIT) begin
      $display("Second UART write completed before the first frame ended");
      ok = 1'b0;
    end
    end_test("uart back to back writes");

    repeat (11 * CLKS_PER_BIT) @(negedge clk);
    access(1, 0, UART_BASE + UART_STAT_OFS, 32'h0, 4'h0, rd, cyc);
    expect_val("imem_rsp.rdata", rd, 32'h0);
    if (rx_bytes.size() != 2 || frame_err) begin
      $display("UART monitor saw %0d frames, framing error %0d", rx_bytes.size(), frame_err);
      ok = 1'b0;
    end else begin
      expect_val("tx_o byte 0", {24'h0, rx_bytes[0]}, 32'h0000_00a5);
      expect_val("tx_o byte 1", {24'h0, rx_bytes[1]}, 32'h0000_003c);
    end
    end_test("uart frames");

    t_now = n_pass + n_fail;
    $display("Tests run: %0d, passed: %0d, failed: %0d", t_now, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== soc_fabric.f ====
src/bus_pkg.sv
src/map_pkg.sv
src/bus_switch.sv
src/ram_slave.sv
src/timer_slave.sv
src/uart_tx_slave.sv
src/soc_fabric.sv
bench/soc_fabric_assert.sv
bench/soc_fabric_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = soc_fabric_tb
FILELIST  = soc_fabric.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o sim_bin
	./$(OBJDIR)/sim_bin > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
